// ==== verilog/pifo_pkg.sv ====
package pifo_pkg;

    // --------------------
    // Widths and sizes
    // --------------------
    localparam int NUM_BRANCH   = 8;                   // Branch slots per node
    localparam int BRANCH_W     = 3;
    localparam int PRIO_W       = 16;
    localparam int META_W       = 8;
    localparam int CNT_W        = 10;                  // Subtree entry count
    localparam int NODE_ADDR_W  = 6;                   // 64 nodes in this level
    localparam int CHILD_ADDR_W = NODE_ADDR_W + BRANCH_W;

    // Priority of a slot that holds nothing
    localparam logic [PRIO_W-1:0] EMPTY_PRIO = '1;

    // --------------------
    // Data types
    // --------------------
    typedef struct packed {
        logic [PRIO_W-1:0] prio;
        logic [META_W-1:0] meta;
    } entry_t;

    // Best entry of a subtree plus its population
    typedef struct packed {
        logic [CNT_W-1:0] cnt;
        entry_t           entry;
    } slot_t;

    typedef slot_t [NUM_BRANCH-1:0] node_t;            // One RAM word

    typedef enum logic {
        OP_PUSH,
        OP_POP
    } op_e;

    typedef struct packed {
        op_e                    op;
        logic [NODE_ADDR_W-1:0] addr;
        entry_t                 entry;
    } req_t;

    // Child address is node address times eight plus branch
    typedef struct packed {
        logic [CHILD_ADDR_W-1:0] addr;
        entry_t                  entry;
    } child_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PUSH,
        ST_POP,
        ST_WB
    } state_e;

endpackage

// ==== verilog/pifo_node_ram.sv ====
module pifo_node_ram (
    input  logic                               i_clk,
    input  logic                               i_arst_n,
    input  logic                               i_rd_en,
    input  logic [pifo_pkg::NODE_ADDR_W-1:0]   i_rd_addr,
    input  logic                               i_wr_en,
    input  logic [pifo_pkg::NODE_ADDR_W-1:0]   i_wr_addr,
    input  pifo_pkg::node_t                    i_wr_node,
    output pifo_pkg::node_t                    o_rd_node
);
    import pifo_pkg::*;

    node_t                        mem [0:2**NODE_ADDR_W-1];
    logic [2**NODE_ADDR_W-1:0]    node_valid;              // Node has been written
    node_t                        empty_node;
    node_t                        rd_q;

    // Word returned for a node that was never written
    always_comb begin
        for (int b = 0; b < NUM_BRANCH; b++) begin
            empty_node[b].cnt        = '0;
            empty_node[b].entry.prio = EMPTY_PRIO;
            empty_node[b].entry.meta = '0;
        end
    end

    // --------------------
    // Write side
    // --------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            node_valid <= '0;
        end else if (i_wr_en) begin
            node_valid[i_wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_node;
        end
    end

    // --------------------
    // Registered read
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            if (i_wr_en && (i_wr_addr == i_rd_addr)) begin
                rd_q <= i_wr_node;                         // Forward the word being written
            end else if (node_valid[i_rd_addr]) begin
                rd_q <= mem[i_rd_addr];
            end else begin
                rd_q <= empty_node;
            end
        end
    end

    assign o_rd_node = rd_q;

endmodule

// ==== verilog/pifo_branch_select.sv ====
module pifo_branch_select (
    input  pifo_pkg::node_t                    i_node,
    output logic [pifo_pkg::BRANCH_W-1:0]      o_min_cnt_idx,
    output logic [pifo_pkg::BRANCH_W-1:0]      o_min_prio_idx
);
    import pifo_pkg::*;

    logic [CNT_W-1:0]    min_cnt;
    logic [PRIO_W-1:0]   min_prio;
    logic [BRANCH_W-1:0] cnt_idx;
    logic [BRANCH_W-1:0] prio_idx;

    // --------------------
    // Arg-min searches
    // --------------------
    // Strict compare keeps the lower index on a tie
    always_comb begin
        min_cnt  = i_node[0].cnt;
        min_prio = i_node[0].entry.prio;
        cnt_idx  = '0;
        prio_idx = '0;

        for (int b = 1; b < NUM_BRANCH; b++) begin
            // Least populated subtree takes the next push
            if (i_node[b].cnt < min_cnt) begin
                min_cnt = i_node[b].cnt;
                cnt_idx = BRANCH_W'(b);
            end

            // Smallest priority leaves on a pop
            if (i_node[b].entry.prio < min_prio) begin
                min_prio = i_node[b].entry.prio;
                prio_idx = BRANCH_W'(b);
            end
        end
    end

    assign o_min_cnt_idx  = cnt_idx;
    assign o_min_prio_idx = prio_idx;

endmodule

// ==== verilog/pifo_node_update.sv ====
module pifo_node_update (
    input  pifo_pkg::state_e                   i_state,
    input  pifo_pkg::node_t                    i_node,
    input  logic [pifo_pkg::BRANCH_W-1:0]      i_min_cnt_idx,
    input  logic [pifo_pkg::BRANCH_W-1:0]      i_min_prio_idx,
    input  pifo_pkg::entry_t                   i_entry,
    input  logic [pifo_pkg::NODE_ADDR_W-1:0]   i_node_addr,
    input  pifo_pkg::entry_t                   i_child_pop_entry,
    output pifo_pkg::node_t                    o_new_node,
    output logic                               o_child_push_valid,
    output pifo_pkg::child_cmd_t               o_child_push,
    output logic                               o_child_pop_valid,
    output logic [pifo_pkg::CHILD_ADDR_W-1:0]  o_child_pop_addr,
    output logic                               o_pop_valid,
    output pifo_pkg::entry_t                   o_pop_entry
);
    import pifo_pkg::*;

    slot_t  push_slot;                                     // Slot picked by count
    slot_t  pop_slot;                                      // Slot picked by priority
    entry_t empty_entry;

    assign push_slot   = i_node[i_min_cnt_idx];
    assign pop_slot    = i_node[i_min_prio_idx];
    assign empty_entry = '{prio: EMPTY_PRIO, meta: '0};

    always_comb begin
        o_new_node         = i_node;
        o_child_push_valid = 1'b0;
        o_child_push       = '0;
        o_child_pop_valid  = 1'b0;
        o_child_pop_addr   = '0;
        o_pop_valid        = 1'b0;
        o_pop_entry        = empty_entry;

        case (i_state)
            // --------------------
            // Push
            // --------------------
            ST_PUSH: begin
                o_new_node[i_min_cnt_idx].cnt = push_slot.cnt + CNT_W'(1);
                o_child_push.addr             = {i_node_addr, i_min_cnt_idx};

                if (push_slot.cnt == '0) begin
                    // Empty slot simply takes the entry
                    o_new_node[i_min_cnt_idx].entry = i_entry;
                end else if (i_entry.prio < push_slot.entry.prio) begin
                    // New entry wins and the old one sinks a level
                    o_new_node[i_min_cnt_idx].entry = i_entry;
                    o_child_push_valid              = 1'b1;
                    o_child_push.entry              = push_slot.entry;
                end else begin
                    o_child_push_valid = 1'b1;         // Equal priority also goes down
                    o_child_push.entry = i_entry;
                end
            end

            // --------------------
            // Pop, then refill
            // --------------------
            ST_POP: begin
                o_pop_valid       = 1'b1;
                o_pop_entry       = pop_slot.entry;    // Empty entry if node is empty
                o_child_pop_addr  = {i_node_addr, i_min_prio_idx};
                o_child_pop_valid = (pop_slot.cnt > CNT_W'(1));
            end

            ST_WB: begin
                if (pop_slot.cnt > CNT_W'(1)) begin
                    // Child answered in this cycle
                    o_new_node[i_min_prio_idx].entry = i_child_pop_entry;
                    o_new_node[i_min_prio_idx].cnt   = pop_slot.cnt - CNT_W'(1);
                end else if (pop_slot.cnt == CNT_W'(1)) begin
                    o_new_node[i_min_prio_idx].entry = empty_entry;
                    o_new_node[i_min_prio_idx].cnt   = '0;
                end
                // A zero count leaves the node as it was
            end

            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/pifo_level_ctrl.sv ====
module pifo_level_ctrl (
    input  logic                               i_clk,
    input  logic                               i_arst_n,
    input  logic                               i_req_valid,
    input  pifo_pkg::req_t                     i_req,
    input  pifo_pkg::node_t                    i_rd_node,
    input  pifo_pkg::node_t                    i_new_node,
    output logic                               o_req_ready,
    output pifo_pkg::state_e                   o_state,
    output logic                               o_rd_en,
    output logic [pifo_pkg::NODE_ADDR_W-1:0]   o_rd_addr,
    output logic                               o_wr_en,
    output logic [pifo_pkg::NODE_ADDR_W-1:0]   o_wr_addr,
    output pifo_pkg::node_t                    o_wr_node,
    output pifo_pkg::node_t                    o_cur_node,
    output logic [pifo_pkg::NODE_ADDR_W-1:0]   o_cur_addr,
    output pifo_pkg::entry_t                   o_cur_entry
);
    import pifo_pkg::*;

    state_e                 state;
    state_e                 state_nxt;
    logic                   accept;
    logic [NODE_ADDR_W-1:0] cur_addr;                      // Node being worked on
    entry_t                 cur_entry;                     // Entry of the latched push
    node_t                  hold_node;                     // Snapshot for write-back

    // Parent is held off only while a pop waits for child data
    assign o_req_ready = (state != ST_POP);
    assign accept      = i_req_valid && o_req_ready;

    // --------------------
    // State machine
    // --------------------
    always_comb begin
        state_nxt = ST_IDLE;
        case (state)
            ST_POP: begin
                state_nxt = ST_WB;
            end
            default: begin
                if (accept) begin
                    state_nxt = (i_req.op == OP_PUSH) ? ST_PUSH : ST_POP;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------
    // Request latch
    // --------------------
    always_ff @(posedge i_clk) begin
        if (accept) begin
            cur_addr  <= i_req.addr;
            cur_entry <= i_req.entry;
        end
    end

    // RAM word seen in ST_POP is kept for the rewrite
    always_ff @(posedge i_clk) begin
        if (state == ST_POP) begin
            hold_node <= i_rd_node;
        end
    end

    assign o_cur_node = (state == ST_WB) ? hold_node : i_rd_node;

    // --------------------
    // RAM access
    // --------------------
    assign o_rd_en   = accept;                             // Read lands in the next cycle
    assign o_rd_addr = i_req.addr;

    assign o_wr_en   = (state == ST_PUSH) || (state == ST_WB);
    assign o_wr_addr = cur_addr;
    assign o_wr_node = i_new_node;

    assign o_state     = state;
    assign o_cur_addr  = cur_addr;
    assign o_cur_entry = cur_entry;

endmodule

// ==== verilog/pifo_level.sv ====
module pifo_level (
    input  logic                               i_clk,
    input  logic                               i_arst_n,
    input  logic                               i_req_valid,
    input  pifo_pkg::req_t                     i_req,
    input  pifo_pkg::entry_t                   i_child_pop_entry,
    output logic                               o_req_ready,
    output logic                               o_pop_valid,
    output pifo_pkg::entry_t                   o_pop_entry,
    output logic                               o_child_push_valid,
    output pifo_pkg::child_cmd_t               o_child_push,
    output logic                               o_child_pop_valid,
    output logic [pifo_pkg::CHILD_ADDR_W-1:0]  o_child_pop_addr
);
    import pifo_pkg::*;

    // --------------------
    // Internal nets
    // --------------------
    state_e                 state;
    logic                   rd_en;
    logic [NODE_ADDR_W-1:0] rd_addr;
    logic                   wr_en;
    logic [NODE_ADDR_W-1:0] wr_addr;
    node_t                  wr_node;
    node_t                  rd_node;
    node_t                  cur_node;
    node_t                  new_node;
    logic [NODE_ADDR_W-1:0] cur_addr;
    entry_t                 cur_entry;
    logic [BRANCH_W-1:0]    min_cnt_idx;
    logic [BRANCH_W-1:0]    min_prio_idx;

    pifo_level_ctrl ctrl_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .i_rd_node   (rd_node),
        .i_new_node  (new_node),
        .o_req_ready (o_req_ready),
        .o_state     (state),
        .o_rd_en     (rd_en),
        .o_rd_addr   (rd_addr),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_node   (wr_node),
        .o_cur_node  (cur_node),
        .o_cur_addr  (cur_addr),
        .o_cur_entry (cur_entry)
    );

    pifo_node_ram ram_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_node (wr_node),
        .o_rd_node (rd_node)
    );

    pifo_branch_select select_i (
        .i_node         (cur_node),
        .o_min_cnt_idx  (min_cnt_idx),
        .o_min_prio_idx (min_prio_idx)
    );

    pifo_node_update update_i (
        .i_state            (state),
        .i_node             (cur_node),
        .i_min_cnt_idx      (min_cnt_idx),
        .i_min_prio_idx     (min_prio_idx),
        .i_entry            (cur_entry),
        .i_node_addr        (cur_addr),
        .i_child_pop_entry  (i_child_pop_entry),
        .o_new_node         (new_node),
        .o_child_push_valid (o_child_push_valid),
        .o_child_push       (o_child_push),
        .o_child_pop_valid  (o_child_pop_valid),
        .o_child_pop_addr   (o_child_pop_addr),
        .o_pop_valid        (o_pop_valid),
        .o_pop_entry        (o_pop_entry)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic o_clk
);

    // 40 unit period
    initial begin
        o_clk = 1'b0;
    end

    always begin
        #20 o_clk = ~o_clk;
    end

endmodule

// ==== tests/pifo_level_asserts.sv ====
module pifo_level_asserts (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  pifo_pkg::state_e i_state,
    input  logic             i_req_ready,
    input  logic             i_wr_en,
    input  logic             i_child_pop_valid
);
    import pifo_pkg::*;

    int fail_count;                                        // Failed assertion count

    initial begin
        fail_count = 0;
    end

    // --------------------
    // Controller rules
    // --------------------
    ready_low_in_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_req_ready == (i_state != ST_POP))
        else begin
            fail_count++;
            $error("Ready does not track the pop state");
        end

    pop_then_wb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_state == ST_POP) |=> (i_state == ST_WB))
        else begin
            fail_count++;
            $error("Pop state not followed by write-back");
        end

    // No RAM write while idle or waiting on the child
    no_write_idle_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wr_en |-> !((i_state == ST_IDLE) || (i_state == ST_POP)))
        else begin
            fail_count++;
            $error("Node write outside push or write-back");
        end

    child_pop_in_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_child_pop_valid |-> (i_state == ST_POP))
        else begin
            fail_count++;
            $error("Child pop outside the pop state");
        end

endmodule

bind pifo_level pifo_level_asserts asserts_i (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .i_state           (state),
    .i_req_ready       (o_req_ready),
    .i_wr_en           (wr_en),
    .i_child_pop_valid (o_child_pop_valid)
);

// ==== tests/pifo_level_tb.sv ====
module pifo_level_tb;
    import pifo_pkg::*;

    localparam int DRIVE_DLY  = 2;
    localparam int TOTAL_REQS = 169;                       // Requests over all tests

    typedef struct packed {
        logic [NODE_ADDR_W-1:0] addr;
        entry_t                 entry;
    } ref_item_t;

    logic                    i_clk;
    logic                    i_arst_n;
    logic                    i_req_valid;
    req_t                    i_req;
    entry_t                  i_child_pop_entry;
    logic                    o_req_ready;
    logic                    o_pop_valid;
    entry_t                  o_pop_entry;
    logic                    o_child_push_valid;
    child_cmd_t              o_child_push;
    logic                    o_child_pop_valid;
    logic [CHILD_ADDR_W-1:0] o_child_pop_addr;
    entry_t                  empty_entry;
    entry_t                  pending;                      // Child answer for the next cycle
    logic                    answer_due;
    ref_item_t               ref_q[$];                     // Reference contents per node
    child_cmd_t              child_q[$];                   // Entries pushed to the child
    int                      errors;
    int                      checks;
    int                      child_push_cnt;
    int                      child_pop_cnt;
    logic [31:0]             lfsr;

    tb_clk_gen clk_gen_i (.o_clk(i_clk));

    pifo_level dut_i (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_req_valid        (i_req_valid),
        .i_req              (i_req),
        .i_child_pop_entry  (i_child_pop_entry),
        .o_req_ready        (o_req_ready),
        .o_pop_valid        (o_pop_valid),
        .o_pop_entry        (o_pop_entry),
        .o_child_push_valid (o_child_push_valid),
        .o_child_push       (o_child_push),
        .o_child_pop_valid  (o_child_pop_valid),
        .o_child_pop_addr   (o_child_pop_addr)
    );

    // --------------------
    // Child model
    // --------------------
    always @(negedge i_clk) begin
        if (o_child_push_valid) begin
            child_q.push_back(o_child_push);
            child_push_cnt++;
        end
        if (o_child_pop_valid) begin
            child_take(o_child_pop_addr, pending);
            child_pop_cnt++;
            answer_due = 1'b1;
        end
    end

    always @(posedge i_clk) begin
        #DRIVE_DLY;
        i_child_pop_entry = answer_due ? pending : empty_entry;   // Answer one cycle later
        answer_due        = 1'b0;
    end

    task automatic child_take(input logic [CHILD_ADDR_W-1:0] addr, output entry_t e);
        int best;
        best = -1;
        for (int k = 0; k < child_q.size(); k++) begin
            if (child_q[k].addr == addr &&
                (best < 0 || child_q[k].entry.prio < child_q[best].entry.prio)) begin
                best = k;
            end
        end
        e = empty_entry;
        if (best >= 0) begin
            e = child_q[best].entry;
            child_q.delete(best);
        end
    endtask

    // Smallest priority still held for that node
    task automatic ref_take(input logic [NODE_ADDR_W-1:0] addr, output entry_t e);
        int best;
        best = -1;
        for (int k = 0; k < ref_q.size(); k++) begin
            if (ref_q[k].addr == addr &&
                (best < 0 || ref_q[k].entry.prio < ref_q[best].entry.prio)) begin
                best = k;
            end
        end
        e = empty_entry;
        if (best >= 0) begin
            e = ref_q[best].entry;
            ref_q.delete(best);
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Low six bits carry the index so priorities in one node never tie
    task automatic rand_entry(input int idx, output entry_t e);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < 18; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        e.prio = {v[17:8], 6'(idx)};
        e.meta = v[7:0];
    endtask

    task automatic send_req(input op_e op, input logic [NODE_ADDR_W-1:0] addr,
                            input entry_t entry);
        i_req_valid = 1'b1;
        i_req       = '{op: op, addr: addr, entry: entry};
        @(negedge i_clk);
        while (!o_req_ready) begin
            @(negedge i_clk);
        end
        @(posedge i_clk);                                  // Accepted here
        #DRIVE_DLY;
        i_req_valid = 1'b0;
    endtask

    task automatic push_req(input logic [NODE_ADDR_W-1:0] addr, input entry_t entry);
        ref_q.push_back('{addr: addr, entry: entry});
        send_req(OP_PUSH, addr, entry);
    endtask

    task automatic pop_check(input logic [NODE_ADDR_W-1:0] addr);
        entry_t exp;
        int     wait_cnt;
        ref_take(addr, exp);
        send_req(OP_POP, addr, '0);
        wait_cnt = 0;
        @(negedge i_clk);
        while (!o_pop_valid && wait_cnt < 8) begin
            wait_cnt++;
            @(negedge i_clk);
        end
        checks++;
        if (!o_pop_valid) begin
            errors++;
            $display("No pop response from node %0d within 8 cycles", addr);
        end else if (o_pop_entry !== exp) begin
            errors++;
            $display("[FAIL] %0t: pop node %0d gave %h/%h, expected %h/%h", $time, addr,
                     o_pop_entry.prio, o_pop_entry.meta, exp.prio, exp.meta);
        end
        @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic reset_and_empty_pop();
        int pops_before;
        @(negedge i_clk);
        checks++;
        if (!o_req_ready || o_pop_valid || o_child_push_valid || o_child_pop_valid) begin
            errors++;
            $display("[FAIL] %0t: outputs not idle after reset", $time);
        end
        @(posedge i_clk);
        #DRIVE_DLY;
        pops_before = child_pop_cnt;
        pop_check(6'd5);                                   // Empty entry expected
        checks++;
        if (child_pop_cnt != pops_before) begin
            errors++;
            $display("[FAIL] %0t: empty node issued a child pop", $time);
        end
    endtask

    task automatic fill_and_drain_node();
        int pushes_before;
        pushes_before = child_push_cnt;
        for (int k = 0; k < NUM_BRANCH; k++) begin
            push_req(6'd2, '{prio: PRIO_W'(800 - 100 * k), meta: 8'(k)});
        end
        repeat (NUM_BRANCH) pop_check(6'd2);
        checks++;
        if (child_push_cnt != pushes_before) begin
            errors++;
            $display("[FAIL] %0t: eight pushes reached the child", $time);
        end
    endtask

    task automatic ninth_push_overflow();
        child_cmd_t exp;
        for (int k = 0; k < NUM_BRANCH; k++) begin
            push_req(6'd9, '{prio: PRIO_W'(100 * (k + 1)), meta: 8'(k)});
        end
        push_req(6'd9, '{prio: PRIO_W'(50), meta: 8'd8});
        // Branch 0 holds prio 100 from the first push and that larger entry sinks
        exp.addr  = CHILD_ADDR_W'(9 * NUM_BRANCH + 0);
        exp.entry = '{prio: PRIO_W'(100), meta: 8'd0};
        @(negedge i_clk);
        checks++;
        if (!o_child_push_valid || o_child_push !== exp) begin
            errors++;
            $display("[FAIL] %0t: ninth push sent %b %h, expected %h", $time,
                     o_child_push_valid, o_child_push, exp);
        end
        @(posedge i_clk);
        #DRIVE_DLY;
        repeat (NUM_BRANCH + 1) pop_check(6'd9);
    endtask

    task automatic random_push_pop_order();
        entry_t e;
        for (int i = 0; i < 40; i++) begin
            rand_entry(i, e);
            push_req(6'd12, e);
        end
        repeat (40) pop_check(6'd12);                      // Child refills most pops
    endtask

    task automatic interleave_two_nodes();
        entry_t e;
        for (int i = 0; i < 12; i++) begin
            rand_entry(i, e);
            push_req(6'd20, e);
            rand_entry(i, e);
            push_req(6'd21, e);
            if (i % 3 == 2) begin
                pop_check(6'd20);
                pop_check(6'd21);
            end
        end
        repeat (8) begin
            pop_check(6'd20);
            pop_check(6'd21);
        end
    endtask

    task automatic push_then_pop_bypass();
        push_req(6'd30, '{prio: PRIO_W'(500), meta: 8'h50});
        push_req(6'd30, '{prio: PRIO_W'(300), meta: 8'h30});
        push_req(6'd30, '{prio: PRIO_W'(100), meta: 8'h10});
        pop_check(6'd30);                                  // Read overlaps the write
        repeat (2) pop_check(6'd30);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        errors            = 0;
        checks            = 0;
        child_push_cnt    = 0;
        child_pop_cnt     = 0;
        lfsr              = 32'h93b;
        empty_entry       = '{prio: EMPTY_PRIO, meta: '0};
        pending           = empty_entry;
        answer_due        = 1'b0;
        i_arst_n          = 1'b0;
        i_req_valid       = 1'b0;
        i_req             = '0;
        i_child_pop_entry = empty_entry;
        repeat (2) @(posedge i_clk);
        #DRIVE_DLY;
        i_arst_n = 1'b1;

        reset_and_empty_pop();
        fill_and_drain_node();
        ninth_push_overflow();
        random_push_pop_order();
        interleave_two_nodes();
        push_then_pop_bypass();

        $display("Checks: %0d, value errors: %0d, assertion errors: %0d",
                 checks, errors, dut_i.asserts_i.fail_count);
        if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Four cycles per request plus reset and slack
    initial begin
        #((TOTAL_REQS * 4 + 60) * 40);
        $display("Watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/pifo_pkg.sv
verilog/pifo_node_ram.sv
verilog/pifo_branch_select.sv
verilog/pifo_node_update.sv
verilog/pifo_level_ctrl.sv
verilog/pifo_level.sv
tests/tb_clk_gen.sv
tests/pifo_level_asserts.sv
tests/pifo_level_tb.sv
